//--- build.f
+incdir+logic
logic/lpif_link_pkg.sv
logic/lpif_link_cfg_apb.sv
logic/lpif_link_auto_sync.sv
logic/lpif_link_name.sv
logic/lpif_link_concat.sv
logic/lpif_link_top.sv
tb/lpif_link_tb.sv

//--- logic/lpif_link_auto_sync.sv
`timescale 1ns/1ps
`default_nettype none

module lpif_link_auto_sync (
  input  wire                            clk_wr,
  input  wire                            arst_n,
  input  wire lpif_link_pkg::link_cfg_t  cfg,
  output logic                           tx_online_delay,
  output logic                           rx_online_delay,
  output lpif_link_pkg::marker_t         tx_auto_mrk,
  output logic                           tx_auto_stb
);

  localparam lpif_link_pkg::delay_t ONE = 1;

  lpif_link_pkg::sync_state_e state;
  lpif_link_pkg::delay_t      tx_cnt;
  lpif_link_pkg::delay_t      rx_cnt;
  logic                       rx_run;

  //////////////////////////////////////////////////
  // TX sequencing, xz then yz
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      state  <= lpif_link_pkg::IDLE;
      tx_cnt <= '0;
    end else if (!cfg.tx_online) begin
      // Offline drops straight back
      state  <= lpif_link_pkg::IDLE;
      tx_cnt <= '0;
    end else begin
      case (state)
        lpif_link_pkg::IDLE: begin
          if (cfg.delay_xz != '0) begin
            state  <= lpif_link_pkg::WAIT_XZ;
            tx_cnt <= cfg.delay_xz;
          end else if (cfg.delay_yz != '0) begin
            state  <= lpif_link_pkg::WAIT_YZ;
            tx_cnt <= cfg.delay_yz;
          end else begin
            state  <= lpif_link_pkg::ONLINE;
          end
        end
        lpif_link_pkg::WAIT_XZ: begin
          if (tx_cnt > ONE) begin
            tx_cnt <= tx_cnt - ONE;
          end else if (cfg.delay_yz != '0) begin
            state  <= lpif_link_pkg::WAIT_YZ;
            tx_cnt <= cfg.delay_yz;
          end else begin
            state  <= lpif_link_pkg::ONLINE;
          end
        end
        lpif_link_pkg::WAIT_YZ: begin
          if (tx_cnt > ONE) begin
            tx_cnt <= tx_cnt - ONE;
          end else begin
            state  <= lpif_link_pkg::ONLINE;
          end
        end
        default: state <= lpif_link_pkg::ONLINE;
      endcase
    end
  end

  // Online once the xz delay has run out
  assign tx_online_delay = (state == lpif_link_pkg::WAIT_YZ) ||
                           (state == lpif_link_pkg::ONLINE);

  // Persistent marker and strobe
  assign tx_auto_mrk = tx_online_delay ? cfg.mrk_userbit : '0;
  assign tx_auto_stb = (state == lpif_link_pkg::ONLINE) & cfg.stb_userbit;

  //////////////////////////////////////////////////
  // RX online delay
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_run          <= 1'b0;
      rx_cnt          <= '0;
      rx_online_delay <= 1'b0;
    end else if (!cfg.rx_online) begin
      rx_run          <= 1'b0;
      rx_cnt          <= '0;
      rx_online_delay <= 1'b0;
    end else if (!rx_run) begin
      // First cycle seen online, load the count
      rx_run          <= 1'b1;
      rx_cnt          <= cfg.delay_x;
      rx_online_delay <= (cfg.delay_x == '0);
    end else if (!rx_online_delay) begin
      if (rx_cnt > ONE) begin
        rx_cnt <= rx_cnt - ONE;
      end else begin
        rx_online_delay <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/lpif_link_cfg_apb.sv
`timescale 1ns/1ps
`default_nettype none
`include "lpif_link_params.svh"

module lpif_link_cfg_apb (
  input  wire                           clk_wr,
  input  wire                           arst_n,
  input  wire lpif_link_pkg::apb_req_t  apb_req,
  output lpif_link_pkg::apb_rsp_t       apb_rsp,
  output lpif_link_pkg::link_cfg_t      cfg,
  output logic [7:0]                    init_credit,
  input  wire                           tx_online_delay,
  input  wire                           rx_online_delay,
  input  wire                           rx_marker_ok,
  input  wire lpif_link_pkg::count_t    tx_count,
  input  wire lpif_link_pkg::count_t    rx_count
);

  lpif_link_pkg::link_cfg_t cfg_q;
  logic [7:0]               credit_q;
  logic                     mrk_err;
  logic                     acc_en;
  logic                     wr_en;
  logic                     hit;
  logic [31:0]              rdata;

  // Access phase, pready is always high
  assign acc_en = apb_req.psel & apb_req.penable;
  assign wr_en  = acc_en & apb_req.pwrite;

  //////////////////////////////////////////////////
  // Read mux and address decode
  always_comb begin
    hit   = 1'b1;
    rdata = '0;
    case (apb_req.paddr)
      `LPIF_REG_CTRL:   rdata = {30'd0, cfg_q.rx_online, cfg_q.tx_online};
      `LPIF_REG_DELAY:  rdata = {8'd0, cfg_q.delay_yz, cfg_q.delay_xz, cfg_q.delay_x};
      `LPIF_REG_USER:   rdata = {29'd0, cfg_q.stb_userbit, cfg_q.mrk_userbit};
      `LPIF_REG_CREDIT: rdata = {24'd0, credit_q};
      `LPIF_REG_STATUS: rdata = {29'd0, mrk_err, rx_online_delay, tx_online_delay};
      `LPIF_REG_TXCNT:  rdata = tx_count;
      `LPIF_REG_RXCNT:  rdata = rx_count;
      default:          hit = 1'b0;
    endcase
  end

  // Error only in the access phase
  assign apb_rsp = '{prdata: rdata, pready: 1'b1, pslverr: acc_en & ~hit};

  //////////////////////////////////////////////////
  // Writable registers
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      cfg_q.tx_online   <= 1'b0;
      cfg_q.rx_online   <= 1'b0;
      {cfg_q.delay_yz, cfg_q.delay_xz, cfg_q.delay_x} <= `LPIF_DELAY_RST;
      cfg_q.mrk_userbit <= '0;
      cfg_q.stb_userbit <= 1'b0;
      credit_q          <= `LPIF_CREDIT_RST;
    end else if (wr_en) begin
      case (apb_req.paddr)
        `LPIF_REG_CTRL:   {cfg_q.rx_online, cfg_q.tx_online} <= apb_req.pwdata[1:0];
        `LPIF_REG_DELAY: begin
          cfg_q.delay_x  <= apb_req.pwdata[7:0];
          cfg_q.delay_xz <= apb_req.pwdata[15:8];
          cfg_q.delay_yz <= apb_req.pwdata[23:16];
        end
        `LPIF_REG_USER:   {cfg_q.stb_userbit, cfg_q.mrk_userbit} <= apb_req.pwdata[2:0];
        `LPIF_REG_CREDIT: credit_q <= apb_req.pwdata[7:0];
        // Status and counters are read only
        default: ;
      endcase
    end
  end

  // Sticky marker error, write one to clear
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      mrk_err <= 1'b0;
    end else if (rx_online_delay && !rx_marker_ok) begin
      mrk_err <= 1'b1;
    end else if (wr_en && (apb_req.paddr == `LPIF_REG_STATUS) && apb_req.pwdata[2]) begin
      mrk_err <= 1'b0;
    end
  end

  assign cfg         = cfg_q;
  assign init_credit = credit_q;

endmodule

`default_nettype wire

//--- logic/lpif_link_concat.sv
`timescale 1ns/1ps
`default_nettype none
`include "lpif_link_params.svh"

module lpif_link_concat (
  input  wire                             clk_wr,
  input  wire                             arst_n,
  input  wire lpif_link_pkg::link_word_t  tx_word,
  output lpif_link_pkg::link_word_t       rx_word,
  output lpif_link_pkg::phy_word_t        tx_phy0,
  output lpif_link_pkg::phy_word_t        tx_phy1,
  input  wire lpif_link_pkg::phy_word_t   rx_phy0,
  input  wire lpif_link_pkg::phy_word_t   rx_phy1,
  input  wire                             tx_online,
  input  wire                             rx_online,
  input  wire lpif_link_pkg::marker_t     tx_mrk,
  input  wire                             tx_stb,
  output logic                            rx_marker_ok
);

  // Two 80 bit words per channel
  localparam int WORD_W = `LPIF_PHY_W / 2;
  localparam int MRK_W  = `LPIF_MRK_W;
  // Word 0 loses marker and strobe, word 1 only the marker
  localparam int W0_PAY = WORD_W - MRK_W - 1;
  localparam int W1_PAY = WORD_W - MRK_W;
  localparam int CH_PAY = W0_PAY + W1_PAY;
  localparam int PAD_W  = 2 * CH_PAY;

  typedef logic [CH_PAY-1:0] ch_pay_t;

  logic [PAD_W-1:0]           tx_pad;
  logic [PAD_W-1:0]           rx_pad;
  lpif_link_pkg::lpif_flit_t  rx_flit;
  logic                       mrk_eq;

  //////////////////////////////////////////////////
  // One channel of payload into a PHY word pair
  function automatic lpif_link_pkg::phy_word_t map_chan(input ch_pay_t pay,
                                                        input lpif_link_pkg::marker_t mrk,
                                                        input logic stb);
    lpif_link_pkg::phy_word_t w;
    // Word 0, strobe sits at bit 1
    w[0]                  = pay[0];
    w[1]                  = stb;
    w[W0_PAY:2]           = pay[W0_PAY-1:1];
    w[WORD_W-1 -: MRK_W]  = mrk;
    // Word 1
    w[WORD_W +: W1_PAY]   = pay[W0_PAY +: W1_PAY];
    w[2*WORD_W-1 -: MRK_W] = mrk;
    return w;
  endfunction

  // Reverse of map_chan, markers and strobe dropped
  function automatic ch_pay_t get_chan(input lpif_link_pkg::phy_word_t w);
    ch_pay_t pay;
    pay[0]                = w[0];
    pay[W0_PAY-1:1]       = w[W0_PAY:2];
    pay[W0_PAY +: W1_PAY] = w[WORD_W +: W1_PAY];
    return pay;
  endfunction

  //////////////////////////////////////////////////
  // TX, zero payload until online
  assign tx_pad = tx_online ? {{(PAD_W - `LPIF_FLIT_W){1'b0}}, tx_word} : '0;

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else begin
      // Lower channel carries the low payload bits
      tx_phy0 <= map_chan(tx_pad[0 +: CH_PAY], tx_mrk, tx_stb);
      tx_phy1 <= map_chan(tx_pad[CH_PAY +: CH_PAY], tx_mrk, tx_stb);
    end
  end

  //////////////////////////////////////////////////
  // RX extraction
  assign rx_pad = {get_chan(rx_phy1), get_chan(rx_phy0)};

  always_comb begin
    rx_flit           = lpif_link_pkg::lpif_flit_t'(rx_pad[`LPIF_FLIT_W-1:0]);
    // Valids held off until rx is online
    rx_flit.valid     = rx_flit.valid & rx_online;
    rx_flit.dvalid    = rx_flit.dvalid & rx_online;
    rx_flit.crc_valid = rx_flit.crc_valid & rx_online;
  end

  // All four markers must agree
  assign mrk_eq = (rx_phy0[WORD_W-1 -: MRK_W]   == rx_phy0[2*WORD_W-1 -: MRK_W]) &&
                  (rx_phy1[WORD_W-1 -: MRK_W]   == rx_phy0[WORD_W-1 -: MRK_W])   &&
                  (rx_phy1[2*WORD_W-1 -: MRK_W] == rx_phy0[WORD_W-1 -: MRK_W]);

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_word      <= '0;
      rx_marker_ok <= 1'b1;
    end else begin
      rx_word      <= lpif_link_pkg::link_word_t'(rx_flit);
      rx_marker_ok <= mrk_eq;
    end
  end

endmodule

`default_nettype wire

//--- logic/lpif_link_name.sv
`timescale 1ns/1ps
`default_nettype none

module lpif_link_name (
  input  wire                             clk_wr,
  input  wire                             arst_n,
  input  wire lpif_link_pkg::lpif_flit_t  dstrm,
  output lpif_link_pkg::lpif_flit_t       ustrm,
  output lpif_link_pkg::link_word_t       tx_word,
  input  wire lpif_link_pkg::link_word_t  rx_word,
  output lpif_link_pkg::count_t           tx_count,
  output lpif_link_pkg::count_t           rx_count
);

  localparam lpif_link_pkg::count_t CNT_ONE = 1;

  //////////////////////////////////////////////////
  // Pack, fields in flit order from the msb
  assign tx_word = {dstrm.state,
                    dstrm.protid,
                    dstrm.data,
                    dstrm.dvalid,
                    dstrm.crc,
                    dstrm.crc_valid,
                    dstrm.valid};

  // Unpack the received word
  always_comb begin
    {ustrm.state,
     ustrm.protid,
     ustrm.data,
     ustrm.dvalid,
     ustrm.crc,
     ustrm.crc_valid,
     ustrm.valid} = rx_word;
  end

  //////////////////////////////////////////////////
  // Flit counters, free running and wrapping
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_count <= '0;
    end else if (dstrm.valid) begin
      tx_count <= tx_count + CNT_ONE;
    end
  end

  // Upstream valid is already gated by rx online
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_count <= '0;
    end else if (ustrm.valid) begin
      rx_count <= rx_count + CNT_ONE;
    end
  end

endmodule

`default_nettype wire

//--- logic/lpif_link_params.svh
`ifndef LPIF_LINK_PARAMS_SVH
`define LPIF_LINK_PARAMS_SVH

// Flit and PHY widths
`define LPIF_FLIT_W     281
`define LPIF_PHY_W      160
`define LPIF_MRK_W      2
`define LPIF_DELAY_W    8
`define LPIF_APB_AW     8

// APB register map
`define LPIF_REG_CTRL   8'h00
`define LPIF_REG_DELAY  8'h04
`define LPIF_REG_USER   8'h08
`define LPIF_REG_CREDIT 8'h0C
`define LPIF_REG_STATUS 8'h10
`define LPIF_REG_TXCNT  8'h14
`define LPIF_REG_RXCNT  8'h18

// Delay fields yz, xz, x from msb down
`define LPIF_DELAY_RST  24'h04_04_04
`define LPIF_CREDIT_RST 8'd8

`endif

//--- logic/lpif_link_pkg.sv
`default_nettype none
`include "lpif_link_params.svh"

package lpif_link_pkg;

  //////////////////////////////////////////////////
  // Vector types
  typedef logic [255:0]               flit_data_t;
  typedef logic [15:0]                flit_crc_t;
  typedef logic [3:0]                 flit_state_t;
  typedef logic [1:0]                 protid_t;
  typedef logic [`LPIF_FLIT_W-1:0]    link_word_t;
  typedef logic [`LPIF_PHY_W-1:0]     phy_word_t;
  typedef logic [`LPIF_DELAY_W-1:0]   delay_t;
  typedef logic [`LPIF_MRK_W-1:0]     marker_t;
  typedef logic [31:0]                count_t;

  //////////////////////////////////////////////////
  // Flit, 281 bits, state in the msbs
  typedef struct packed {
    flit_state_t state;
    protid_t     protid;
    flit_data_t  data;
    logic        dvalid;
    flit_crc_t   crc;
    logic        crc_valid;
    logic        valid;
  } lpif_flit_t;

  //////////////////////////////////////////////////
  // APB slave side
  typedef struct packed {
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [`LPIF_APB_AW-1:0]  paddr;
    logic [31:0]              pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // Link configuration from the register block
  typedef struct packed {
    logic    tx_online;
    logic    rx_online;
    delay_t  delay_x;
    delay_t  delay_xz;
    delay_t  delay_yz;
    marker_t mrk_userbit;
    logic    stb_userbit;
  } link_cfg_t;

  // TX online sequencing
  typedef enum logic [1:0] {
    IDLE,
    WAIT_XZ,
    WAIT_YZ,
    ONLINE
  } sync_state_e;

endpackage

`default_nettype wire

//--- logic/lpif_link_top.sv
`timescale 1ns/1ps
`default_nettype none

module lpif_link_top (
  input  wire                             clk_wr,
  input  wire                             arst_n,
  // Configuration
  input  wire lpif_link_pkg::apb_req_t    apb_req,
  output lpif_link_pkg::apb_rsp_t         apb_rsp,
  // Flit channels
  input  wire lpif_link_pkg::lpif_flit_t  dstrm,
  output lpif_link_pkg::lpif_flit_t       ustrm,
  // PHY channels
  output lpif_link_pkg::phy_word_t        tx_phy0,
  output lpif_link_pkg::phy_word_t        tx_phy1,
  input  wire lpif_link_pkg::phy_word_t   rx_phy0,
  input  wire lpif_link_pkg::phy_word_t   rx_phy1
);

  //////////////////////////////////////////////////
  // Interconnect
  lpif_link_pkg::link_cfg_t   cfg;
  logic                       tx_online_delay;
  logic                       rx_online_delay;
  lpif_link_pkg::marker_t     tx_auto_mrk;
  logic                       tx_auto_stb;
  lpif_link_pkg::link_word_t  tx_word;
  lpif_link_pkg::link_word_t  rx_word;
  logic                       rx_marker_ok;
  lpif_link_pkg::count_t      tx_count;
  lpif_link_pkg::count_t      rx_count;

  //////////////////////////////////////////////////
  // Registers
  lpif_link_cfg_apb u_cfg_apb (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .apb_req         (apb_req),
    .apb_rsp         (apb_rsp),
    .cfg             (cfg),
    // No credit logic in this endpoint
    .init_credit     (),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .rx_marker_ok    (rx_marker_ok),
    .tx_count        (tx_count),
    .rx_count        (rx_count)
  );

  // Online sequencing
  lpif_link_auto_sync u_auto_sync (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .cfg             (cfg),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_auto_mrk     (tx_auto_mrk),
    .tx_auto_stb     (tx_auto_stb)
  );

  // Flit pack and counters
  lpif_link_name u_name (
    .clk_wr   (clk_wr),
    .arst_n   (arst_n),
    .dstrm    (dstrm),
    .ustrm    (ustrm),
    .tx_word  (tx_word),
    .rx_word  (rx_word),
    .tx_count (tx_count),
    .rx_count (rx_count)
  );

  // PHY mapping
  lpif_link_concat u_concat (
    .clk_wr       (clk_wr),
    .arst_n       (arst_n),
    .tx_word      (tx_word),
    .rx_word      (rx_word),
    .tx_phy0      (tx_phy0),
    .tx_phy1      (tx_phy1),
    .rx_phy0      (rx_phy0),
    .rx_phy1      (rx_phy1),
    .tx_online    (tx_online_delay),
    .rx_online    (rx_online_delay),
    .tx_mrk       (tx_auto_mrk),
    .tx_stb       (tx_auto_stb),
    .rx_marker_ok (rx_marker_ok)
  );

endmodule

`default_nettype wire

//--- tb/lpif_link_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "lpif_link_params.svh"

module lpif_link_tb;

  localparam int WORD_W    = `LPIF_PHY_W / 2;
  localparam int APB_LIMIT = 16;

  logic                       clk_wr;
  logic                       arst_n;
  lpif_link_pkg::apb_req_t    apb_req;
  lpif_link_pkg::apb_rsp_t    apb_rsp;
  lpif_link_pkg::lpif_flit_t  dstrm;
  lpif_link_pkg::lpif_flit_t  ustrm;
  lpif_link_pkg::phy_word_t   tx_phy0;
  lpif_link_pkg::phy_word_t   tx_phy1;

  logic [15:0] lfsr;
  logic        timed_out;
  int          err_count;
  int          check_count;
  int          tests_run;
  int          test_errs;
  int          test_checks;
  string       test_name;

  // PHY looped straight back
  lpif_link_top DUT (
    .clk_wr  (clk_wr),
    .arst_n  (arst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .dstrm   (dstrm),
    .ustrm   (ustrm),
    .tx_phy0 (tx_phy0),
    .tx_phy1 (tx_phy1),
    .rx_phy0 (tx_phy0),
    .rx_phy1 (tx_phy1)
  );

  initial begin
    clk_wr = 1'b0;
    forever #4 clk_wr = ~clk_wr;
  end

  //////////////////////////////////////////////////
  // Checking and random source
  task automatic check_value(input string what, input logic [`LPIF_FLIT_W-1:0] got,
                             input logic [`LPIF_FLIT_W-1:0] exp);
    check_count++;
    test_checks++;
    if (got !== exp) begin
      err_count++;
      test_errs++;
      $display("error at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string why);
    err_count++;
    test_errs++;
    timed_out = 1'b1;
    $display("timeout at %0t ns: %s", $time, why);
  endtask

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // One LFSR step per flit bit and valid forced high
  task automatic make_flit(output lpif_link_pkg::lpif_flit_t f);
    logic [`LPIF_FLIT_W-1:0] v;
    for (int i = 0; i < `LPIF_FLIT_W; i++) begin
      lfsr = lfsr_next(lfsr);
      v[i] = lfsr[0];
    end
    f       = v;
    f.valid = 1'b1;
  endtask

  //////////////////////////////////////////////////
  // APB master with a setup then an access phase
  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr);
    int waited;
    waited = 0;
    @(negedge clk_wr);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk_wr);
    apb_req.penable = 1'b1;
    @(posedge clk_wr);
    while (!apb_rsp.pready && waited < APB_LIMIT) begin
      @(posedge clk_wr);
      waited++;
    end
    if (!apb_rsp.pready) begin
      report_timeout($sformatf("no pready for APB access to offset %h", addr));
    end
    // Response as seen at the completing edge
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(negedge clk_wr);
    apb_req = '0;
  endtask

  // Poll the status register until one bit has a value
  task automatic wait_status(input int bit_idx, input int value, input int limit);
    logic [31:0] rd;
    logic        err;
    int          polls;
    polls = 0;
    apb_access(1'b0, `LPIF_REG_STATUS, '0, rd, err);
    while (rd[bit_idx] !== value[0] && polls < limit && !timed_out) begin
      apb_access(1'b0, `LPIF_REG_STATUS, '0, rd, err);
      polls++;
    end
    if (!timed_out && rd[bit_idx] !== value[0]) begin
      report_timeout($sformatf("status bit %0d never reached %0d", bit_idx, value));
    end
  endtask

  // Markers in all four PHY words once the word 0 strobe of each channel is up
  task automatic check_markers(input logic [1:0] mrk, input logic stb, input int limit);
    int waited;
    waited = 0;
    while ((tx_phy0[1] !== stb || tx_phy1[1] !== stb) && waited < limit) begin
      @(negedge clk_wr);
      waited++;
    end
    if (tx_phy0[1] !== stb || tx_phy1[1] !== stb) begin
      report_timeout("strobe never reached its programmed value");
    end else begin
      check_value("tx markers", {tx_phy0[WORD_W-1 -: 2], tx_phy0[2*WORD_W-1 -: 2],
                                 tx_phy1[WORD_W-1 -: 2], tx_phy1[2*WORD_W-1 -: 2]}, {4{mrk}});
    end
  endtask

  //////////////////////////////////////////////////
  // Flit burst with a loopback latency of two cycles
  task automatic run_burst(input int count, input logic rx_on);
    lpif_link_pkg::lpif_flit_t f;
    lpif_link_pkg::lpif_flit_t exp_f;
    lpif_link_pkg::lpif_flit_t exp_q[$];
    for (int i = 0; i < count + 2; i++) begin
      @(negedge clk_wr);
      if (rx_on && i >= 2) begin
        exp_f = exp_q.pop_front();
        check_value($sformatf("loopback flit %0d", i - 2), ustrm, exp_f);
      end
      // RX offline holds every valid low
      if (!rx_on) begin
        check_value("gated valids", {ustrm.valid, ustrm.dvalid, ustrm.crc_valid}, '0);
      end
      if (i < count) begin
        make_flit(f);
        dstrm = f;
        exp_q.push_back(f);
      end else begin
        dstrm = '0;
      end
    end
  endtask

  task automatic end_test();
    if (test_name != "") begin
      $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errs);
      tests_run++;
    end
    test_checks = 0;
    test_errs   = 0;
  endtask

  //////////////////////////////////////////////////
  // Main sequence from the data file
  initial begin
    int          fd;
    int          code;
    int          v1;
    int          v2;
    int          v3;
    string       line;
    string       cmd;
    string       name;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] rd;
    logic        err;
    arst_n      = 1'b0;
    apb_req     = '0;
    dstrm       = '0;
    lfsr        = 16'd70;
    timed_out   = 1'b0;
    err_count   = 0;
    check_count = 0;
    tests_run   = 0;
    test_errs   = 0;
    test_checks = 0;
    test_name   = "";
    repeat (5) @(posedge clk_wr);
    @(negedge clk_wr);
    arst_n = 1'b1;

    fd = $fopen("tb/lpif_link_testdata.txt", "r");
    if (fd == 0) begin
      err_count++;
      $display("could not open the test data file");
    end else begin
      while (!$feof(fd) && !timed_out) begin
        line = "";
        code = $fgets(line, fd);
        if (code == 0 || line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n") begin
          continue;
        end
        code = $sscanf(line, "%s", cmd);
        case (cmd)
          "T": begin
            end_test();
            code      = $sscanf(line, "%s %s", cmd, name);
            test_name = name;
          end
          "W": begin
            code = $sscanf(line, "%s %h %h", cmd, addr, data);
            apb_access(1'b1, addr[7:0], data, rd, err);
            check_value($sformatf("write %h pslverr", addr[7:0]), err, 1'b0);
          end
          "R": begin
            code = $sscanf(line, "%s %h %h %d", cmd, addr, data, v1);
            apb_access(1'b0, addr[7:0], '0, rd, err);
            check_value($sformatf("read %h data", addr[7:0]), rd, data);
            check_value($sformatf("read %h pslverr", addr[7:0]), err, v1[0]);
          end
          "S": begin
            code = $sscanf(line, "%s %d %d %d", cmd, v1, v2, v3);
            wait_status(v1, v2, v3);
          end
          "K": begin
            code = $sscanf(line, "%s %d %d %d", cmd, v1, v2, v3);
            check_markers(v1[1:0], v2[0], v3);
          end
          "F": begin
            code = $sscanf(line, "%s %d %d", cmd, v1, v2);
            run_burst(v1, v2[0]);
          end
          "Z": begin
            // Reset state of the PHY and upstream outputs
            check_value("tx_phy0 after reset", tx_phy0, '0);
            check_value("tx_phy1 after reset", tx_phy1, '0);
            check_value("ustrm valids after reset",
                        {ustrm.valid, ustrm.dvalid, ustrm.crc_valid}, '0);
          end
          default: begin
            err_count++;
            $display("unknown command in test data: %s", cmd);
          end
        endcase
      end
      $fclose(fd);
      end_test();
    end

    $display("tests %0d, checks %0d, errors %0d", tests_run, check_count, err_count);
    if (err_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/lpif_link_testdata.txt
# T name | W addr data | R addr data slverr | S status_bit value poll_limit
# K marker strobe cycle_limit | F flit_count rx_online | Z reset output check
T reset_values
Z
R 00 00000000 0
R 04 00040404 0
R 08 00000000 0
R 0C 00000008 0
R 10 00000000 0
R 14 00000000 0
R 18 00000000 0
T reg_write_read
W 04 00030502
R 04 00030502 0
W 08 00000005
R 08 00000005 0
W 0C 00000022
R 0C 00000022 0
T unmapped_and_status
R 1C 00000000 1
R 40 00000000 1
W 10 00000003
R 10 00000000 0
T online_sequence
W 00 00000003
R 00 00000003 0
S 0 1 40
S 1 1 40
K 1 1 40
T loopback
F 16 1
T rx_offline
W 00 00000001
S 1 0 10
F 8 0
T counters
R 14 00000018 0
R 18 00000010 0
R 10 00000001 0
W 00 00000003
S 1 1 40
F 10 1
R 14 00000022 0
R 18 0000001A 0
R 10 00000003 0
